//--- src.f
+incdir+src
src/periph_pkg.sv
src/periph_decode.sv
src/gpio_regs.sv
src/hwrng.sv
src/irq_ctrl.sv
src/periph_top.sv
tests/tb_periph_top.sv

//--- Makefile
# Verilator build and run for the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_periph_top.sv
/*
 * Testbench for the peripheral block: clock and reset,
 * stimulus table with expected responses, LFSR model,
 * response and pin checks, cycle timeout
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module tb_periph_top
    import periph_pkg::*;
();

    localparam logic [1:0] KIND_IDLE  = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_WRITE = 2'd2;

    localparam logic [7:0] A_GPIO     = 8'h00;
    localparam logic [7:0] A_RNG_DATA = 8'h20;
    localparam logic [7:0] A_RNG_STAT = 8'h24;
    localparam logic [7:0] A_IRQ_EN   = 8'h40;
    localparam logic [7:0] A_IRQ_PEND = 8'h44;
    localparam logic [7:0] A_NONE     = 8'h60;

    localparam int MAX_ROWS = 96;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       req_i;
    logic       we_i;
    logic [7:0] addr_i;
    logic [3:0] be_i;
    word_t      wdata_i;
    logic [7:0] dip_switches_i;
    word_t      rdata_o;
    logic       err_o;
    logic       rvalid_o;
    logic [7:0] leds_o;
    logic [1:0] irq_o;

    // --------------------
    // Stimulus table
    // --------------------
    logic [1:0] t_kind [MAX_ROWS];
    logic [7:0] t_addr [MAX_ROWS];
    logic [3:0] t_be   [MAX_ROWS];
    word_t      t_data [MAX_ROWS];
    logic [7:0] t_dip  [MAX_ROWS];
    word_t      t_exp  [MAX_ROWS];
    word_t      t_mask [MAX_ROWS];
    logic       t_err  [MAX_ROWS];
    logic       t_lfsr [MAX_ROWS];   // Expected data comes from the model
    logic       t_pins [MAX_ROWS];
    logic [7:0] t_leds [MAX_ROWS];
    logic [1:0] t_irq  [MAX_ROWS];
    int         t_group [MAX_ROWS];

    string      group_name [6];
    int         n_entries;
    int         cur_group;
    logic [7:0] cur_dip;
    word_t      lfsr_model;
    integer     seed = 54092;
    int         cycles = 0;
    int         cycle_limit = 1000;
    int         group_errors = 0;
    int         total_errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    periph_top UUT (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .be_i           (be_i),
        .wdata_i        (wdata_i),
        .rdata_o        (rdata_o),
        .err_o          (err_o),
        .rvalid_o       (rvalid_o),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o),
        .irq_o          (irq_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not complete", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // One generator step shifts left and feeds back taps 31, 21, 1 and 0
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic store_row(input logic [1:0] kind, input logic [7:0] addr,
                             input logic [3:0] be, input word_t data,
                             input word_t exp, input word_t mask, input logic err);
        t_kind[n_entries]  = kind;
        t_addr[n_entries]  = addr;
        t_be[n_entries]    = be;
        t_data[n_entries]  = data;
        t_dip[n_entries]   = cur_dip;
        t_exp[n_entries]   = exp;
        t_mask[n_entries]  = mask;
        t_err[n_entries]   = err;
        t_lfsr[n_entries]  = 1'b0;
        t_pins[n_entries]  = 1'b0;
        t_leds[n_entries]  = 8'h00;
        t_irq[n_entries]   = 2'b00;
        t_group[n_entries] = cur_group;
        n_entries = n_entries + 1;
    endtask

    task automatic read_req(input logic [7:0] addr, input word_t exp);
        store_row(KIND_READ, addr, 4'hF, '0, exp, '1, 1'b0);
    endtask

    // Write responses carry don't-care data
    task automatic write_req(input logic [7:0] addr, input logic [3:0] be, input word_t data);
        store_row(KIND_WRITE, addr, be, data, '0, '0, 1'b0);
    endtask

    task automatic idle_slot();
        store_row(KIND_IDLE, 8'h00, 4'h0, '0, '0, '0, 1'b0);
    endtask

    task automatic rng_word_read();
        store_row(KIND_READ, A_RNG_DATA, 4'hF, '0, '0, '1, 1'b0);
        t_lfsr[n_entries - 1] = 1'b1;
    endtask

    // Pin values checked after the last stored row
    task automatic expect_pins(input logic [7:0] leds, input logic [1:0] irq);
        t_pins[n_entries - 1] = 1'b1;
        t_leds[n_entries - 1] = leds;
        t_irq[n_entries - 1]  = irq;
    endtask

    task automatic build_table();
        word_t      led_wr;
        word_t      led_skip;
        word_t      junk;
        word_t      rnd;
        logic [7:0] dip_a;
        logic [7:0] dip_b;
        led_wr   = $random(seed);
        led_skip = $random(seed);
        junk     = $random(seed);
        rnd      = $random(seed);
        dip_a    = rnd[7:0];
        dip_b    = dip_a ^ (rnd[15:8] | 8'h01);   // Always differs
        cur_dip  = dip_a;
        n_entries = 0;

        cur_group = 0;
        read_req(A_RNG_STAT, 32'h4000_0000);       // Empty only
        expect_pins(8'h00, 2'b00);

        cur_group = 1;
        write_req(A_GPIO, 4'b0001, led_wr);
        expect_pins(led_wr[7:0], 2'b00);
        write_req(A_GPIO, 4'b1110, led_skip);      // LEDs hold without byte 0
        expect_pins(led_wr[7:0], 2'b00);
        read_req(A_GPIO, {24'h0, dip_a});

        cur_group = 2;
        store_row(KIND_READ, A_NONE, 4'hF, '0, 32'hDEAD_BEEF, '1, 1'b1);
        store_row(KIND_WRITE, A_NONE | 8'h04, 4'hF, junk, 32'hDEAD_BEEF, '1, 1'b1);
        read_req(A_GPIO, {24'h0, dip_a});
        expect_pins(led_wr[7:0], 2'b00);

        cur_group = 3;
        write_req(A_RNG_STAT, 4'hF, 32'h1);
        repeat (9) idle_slot();
        read_req(A_RNG_STAT, 32'h8000_1010);       // Full, run, level 16
        write_req(A_RNG_STAT, 4'hF, 32'h0);
        repeat (16) begin
            rng_word_read();
            write_req(A_RNG_DATA, 4'hF, junk);
        end
        read_req(A_RNG_STAT, 32'h4010_0000);       // Empty, 16 pops

        cur_group = 4;
        write_req(A_RNG_DATA, 4'hF, junk);
        read_req(A_RNG_STAT, 32'h6010_0000);
        write_req(A_RNG_STAT, 4'hF, 32'h2);
        read_req(A_RNG_STAT, 32'h4010_0000);

        cur_group = 5;
        write_req(A_IRQ_EN, 4'hF, 32'h4);          // Source 0 to target 1
        read_req(A_IRQ_PEND, 32'h0);
        expect_pins(led_wr[7:0], 2'b00);
        write_req(A_RNG_STAT, 4'hF, 32'h1);
        idle_slot();
        read_req(A_IRQ_PEND, 32'h1);
        expect_pins(led_wr[7:0], 2'b10);
        write_req(A_IRQ_EN, 4'hF, 32'h6);          // Add source 1 to target 0
        cur_dip = dip_b;
        idle_slot();
        read_req(A_IRQ_PEND, 32'h3);
        expect_pins(led_wr[7:0], 2'b11);
        read_req(A_GPIO, {24'h0, dip_b});
        write_req(A_IRQ_PEND, 4'hF, 32'h2);
        read_req(A_IRQ_PEND, 32'h1);
        expect_pins(led_wr[7:0], 2'b10);
    endtask

    task automatic run_entry(input int i);
        int    waited;
        word_t exp;
        exp = t_exp[i];
        if (t_lfsr[i]) begin
            exp = lfsr_model;
            lfsr_model = lfsr_next(lfsr_model);
        end
        @(posedge clk_i);
        #2;
        // The edge just passed carried no request
        if (rvalid_o !== 1'b0) begin
            $display("FAIL entry %0d rvalid_o: got %h, expected %h", i, rvalid_o, 1'b0);
            group_errors = group_errors + 1;
        end
        dip_switches_i = t_dip[i];
        req_i   = (t_kind[i] != KIND_IDLE);
        we_i    = (t_kind[i] == KIND_WRITE);
        addr_i  = t_addr[i];
        be_i    = t_be[i];
        wdata_i = t_data[i];
        @(posedge clk_i);
        #2;
        req_i = 1'b0;
        we_i  = 1'b0;
        if (t_kind[i] != KIND_IDLE) begin
            waited = 0;
            while (!rvalid_o && waited < 3) begin
                @(posedge clk_i);
                #2;
                waited = waited + 1;
            end
            if (!rvalid_o) begin
                $display("Entry %0d got no response from the DUT", i);
                group_errors = group_errors + 1;
            end else begin
                if (waited != 0) begin
                    $display("Entry %0d got its response %0d cycles late", i, waited);
                    group_errors = group_errors + 1;
                end
                if ((rdata_o & t_mask[i]) !== (exp & t_mask[i])) begin
                    $display("FAIL entry %0d rdata_o: got %h, expected %h", i, rdata_o, exp);
                    group_errors = group_errors + 1;
                end
                if (err_o !== t_err[i]) begin
                    $display("FAIL entry %0d err_o: got %h, expected %h", i, err_o, t_err[i]);
                    group_errors = group_errors + 1;
                end
            end
        end
        if (t_pins[i]) begin
            if (leds_o !== t_leds[i]) begin
                $display("FAIL entry %0d leds_o: got %h, expected %h", i, leds_o, t_leds[i]);
                group_errors = group_errors + 1;
            end
            if (irq_o !== t_irq[i]) begin
                $display("FAIL entry %0d irq_o: got %h, expected %h", i, irq_o, t_irq[i]);
                group_errors = group_errors + 1;
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        group_name[0] = "reset state";
        group_name[1] = "GPIO";
        group_name[2] = "absent slot";
        group_name[3] = "RNG fill and drain";
        group_name[4] = "read error";
        group_name[5] = "interrupts";
        lfsr_model = `RNG_SEED;
        build_table();
        cycle_limit = 4 * n_entries + 50;

        reset_i        = 1'b1;
        req_i          = 1'b0;
        we_i           = 1'b0;
        addr_i         = 8'h00;
        be_i           = 4'h0;
        wdata_i        = '0;
        dip_switches_i = t_dip[0];
        repeat (2) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
            if (i == n_entries - 1 || t_group[i + 1] != t_group[i]) begin
                if (group_errors == 0) begin
                    $display("PASS test %0d (%s)", t_group[i], group_name[t_group[i]]);
                    tests_passed = tests_passed + 1;
                end else begin
                    $display("FAIL test %0d (%s), %0d errors", t_group[i],
                             group_name[t_group[i]], group_errors);
                    tests_failed = tests_failed + 1;
                end
                total_errors = total_errors + group_errors;
                group_errors = 0;
            end
        end

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- src/periph_top.sv
/*
 * Peripheral block top level: request decoder, GPIO,
 * random number source and interrupt controller
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Request port
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [`PERIPH_ADDR_W-1:0]   addr_i,
    input  logic [`PERIPH_DATA_W/8-1:0] be_i,
    input  word_t                       wdata_i,
    output word_t                       rdata_o,
    output logic                        err_o,
    output logic                        rvalid_o,
    // Board I/O
    input  logic [7:0]                  dip_switches_i,
    output logic [7:0]                  leds_o,
    output logic [`NUM_IRQ_TARGETS-1:0] irq_o
);

    // --------------------
    // Internal bus
    // --------------------
    logic                        gpio_sel;
    logic                        rng_sel;
    logic                        irq_sel;
    logic                        bus_we;
    logic                        bus_word;
    logic [`PERIPH_DATA_W/8-1:0] bus_be;
    word_t                       bus_wdata;
    word_t                       gpio_rdata;
    word_t                       rng_rdata;
    word_t                       irq_rdata;
    logic                        rng_not_empty;
    logic                        dip_change;

    periph_decode u_decode (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .be_i         (be_i),
        .wdata_i      (wdata_i),
        .gpio_rdata_i (gpio_rdata),
        .rng_rdata_i  (rng_rdata),
        .irq_rdata_i  (irq_rdata),
        .gpio_sel_o   (gpio_sel),
        .rng_sel_o    (rng_sel),
        .irq_sel_o    (irq_sel),
        .we_o         (bus_we),
        .word_o       (bus_word),
        .be_o         (bus_be),
        .wdata_o      (bus_wdata),
        .rdata_o      (rdata_o),
        .err_o        (err_o),
        .rvalid_o     (rvalid_o)
    );

    gpio_regs u_gpio (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sel_i          (gpio_sel),
        .we_i           (bus_we),
        .be_i           (bus_be),
        .wdata_i        (bus_wdata),
        .dip_switches_i (dip_switches_i),
        .rdata_o        (gpio_rdata),
        .leds_o         (leds_o),
        .dip_change_o   (dip_change)
    );

    hwrng u_rng (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .sel_i       (rng_sel),
        .we_i        (bus_we),
        .word_i      (bus_word),
        .wdata_i     (bus_wdata),
        .rdata_o     (rng_rdata),
        .not_empty_o (rng_not_empty)
    );

    irq_ctrl u_irq (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .sel_i        (irq_sel),
        .we_i         (bus_we),
        .word_i       (bus_word),
        .wdata_i      (bus_wdata),
        .rng_irq_i    (rng_not_empty),   // Source 0
        .dip_change_i (dip_change),      // Source 1
        .rdata_o      (irq_rdata),
        .irq_o        (irq_o)
    );

endmodule

//--- src/irq_ctrl.sv
/*
 * Interrupt controller: enable register, pending vector
 * and registered per-target interrupt outputs
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module irq_ctrl
    import periph_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        sel_i,
    input  logic                        we_i,
    input  logic                        word_i,
    input  word_t                       wdata_i,
    input  logic                        rng_irq_i,
    input  logic                        dip_change_i,
    output word_t                       rdata_o,
    output logic [`NUM_IRQ_TARGETS-1:0] irq_o
);

    localparam int NSRC = `NUM_IRQ_SOURCES;
    localparam int EN_W = `NUM_IRQ_TARGETS * `NUM_IRQ_SOURCES;

    logic [EN_W-1:0] enable;     // One group of NSRC bits per target
    logic [NSRC-1:0] pending;
    logic            dip_pend;

    assign pending = {dip_pend, rng_irq_i};   // Source 0 is a level

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable   <= '0;
            dip_pend <= 1'b0;
        end else begin
            if (sel_i && we_i && !word_i) begin
                enable <= wdata_i[EN_W-1:0];
            end
            // New change wins over a clear in the same cycle
            if (dip_change_i) begin
                dip_pend <= 1'b1;
            end else if (sel_i && we_i && word_i && wdata_i[1]) begin
                dip_pend <= 1'b0;
            end
        end
    end

    // Per-target outputs
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_o <= '0;
        end else begin
            for (int t = 0; t < `NUM_IRQ_TARGETS; t++) begin
                irq_o[t] <= |(pending & enable[t*NSRC +: NSRC]);
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (word_i) begin
            rdata_o[NSRC-1:0] = pending;
        end else begin
            rdata_o[EN_W-1:0] = enable;
        end
    end

endmodule

//--- src/hwrng.sv
/*
 * Hardware random number slot: 32-bit LFSR generator,
 * 16-entry FIFO with level and pop counters, run control,
 * sticky read error and status word
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module hwrng
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  sel_i,
    input  logic  we_i,
    input  logic  word_i,
    input  word_t wdata_i,
    output word_t rdata_o,
    output logic  not_empty_o
);

    localparam int PTR_W = $clog2(`RNG_FIFO_DEPTH);

    word_t                 lfsr_q;
    word_t                 fifo_mem [`RNG_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`RNG_CNT_W-1:0] level;
    logic [`RNG_CNT_W-1:0] pop_cnt;
    logic                  run;
    logic                  rd_err;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop_req;
    logic                  pop;
    logic                  ctrl_wr;
    word_t                 status;

    assign full  = (level == `RNG_CNT_W'(`RNG_FIFO_DEPTH));
    assign empty = (level == '0);

    assign push    = run && !full;                  // Full FIFO pauses the generator
    assign pop_req = sel_i && we_i && !word_i;      // Any data pops
    assign pop     = pop_req && !empty;
    assign ctrl_wr = sel_i && we_i && word_i;

    // --------------------
    // Generator
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lfsr_q <= `RNG_SEED;
        end else if (push) begin
            // Taps 31, 21, 1, 0
            lfsr_q <= {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        end
    end

    // --------------------
    // FIFO
    // --------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr] <= lfsr_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            pop_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                pop_cnt <= pop_cnt + 1'b1; // Modulo 512
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;   // Both or neither
            endcase
        end
    end

    // Run control and read error
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            run    <= 1'b0;
            rd_err <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                run <= wdata_i[0];
            end
            if (pop_req && empty) begin
                rd_err <= 1'b1;            // Sticky
            end else if (ctrl_wr && wdata_i[1]) begin
                rd_err <= 1'b0;
            end
        end
    end

    // --------------------
    // Read side
    // --------------------
    assign status = {full, empty, rd_err, 1'b0,
                     3'b000, pop_cnt,
                     3'b000, run,
                     3'b000, level};

    always_comb begin
        if (word_i) begin
            rdata_o = status;
        end else if (empty) begin
            rdata_o = '0;
        end else begin
            rdata_o = fifo_mem[rd_ptr];    // Head of FIFO
        end
    end

    assign not_empty_o = !empty;

endmodule

//--- src/gpio_regs.sv
/*
 * GPIO slot: LED register written under byte enable 0,
 * DIP switch sampling with change detect
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module gpio_regs
    import periph_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        sel_i,
    input  logic                        we_i,
    input  logic [`PERIPH_DATA_W/8-1:0] be_i,
    input  word_t                       wdata_i,
    input  logic [7:0]                  dip_switches_i,
    output word_t                       rdata_o,
    output logic [7:0]                  leds_o,
    output logic                        dip_change_o
);

    logic [7:0] dip_q;
    logic       dip_seen;   // First sample taken

    // --------------------
    // LEDs
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            leds_o <= 8'h00;
        end else if (sel_i && we_i && be_i[0]) begin
            leds_o <= wdata_i[7:0];
        end
    end

    // --------------------
    // DIP switches
    // --------------------
    always_ff @(posedge clk_i) begin
        dip_q <= dip_switches_i;   // Sampled every cycle
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dip_seen     <= 1'b0;
            dip_change_o <= 1'b0;
        end else begin
            dip_seen     <= 1'b1;
            // Previous sample is stale until the first one lands
            dip_change_o <= dip_seen && (dip_switches_i != dip_q);
        end
    end

    assign rdata_o = {{(`PERIPH_DATA_W-8){1'b0}}, dip_q};

endmodule

//--- src/periph_decode.sv
/*
 * Request decoder: slot select strobes, shared write bus,
 * read data mux and one-cycle registered response
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_decode
    import periph_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    // Request port
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [`PERIPH_ADDR_W-1:0]  addr_i,
    input  logic [`PERIPH_DATA_W/8-1:0] be_i,
    input  word_t                      wdata_i,
    // Peripheral read data
    input  word_t                      gpio_rdata_i,
    input  word_t                      rng_rdata_i,
    input  word_t                      irq_rdata_i,
    // To peripherals
    output logic                       gpio_sel_o,
    output logic                       rng_sel_o,
    output logic                       irq_sel_o,
    output logic                       we_o,
    output logic                       word_o,
    output logic [`PERIPH_DATA_W/8-1:0] be_o,
    output word_t                      wdata_o,
    // Response
    output word_t                      rdata_o,
    output logic                       err_o,
    output logic                       rvalid_o
);

    periph_slot_e slot;
    word_t        rsp_data;

    assign slot = periph_slot_e'(addr_i[6:5]);

    // One strobe per populated slot, only during a request
    assign gpio_sel_o = req_i && (slot == SLOT_GPIO);
    assign rng_sel_o  = req_i && (slot == SLOT_RNG);
    assign irq_sel_o  = req_i && (slot == SLOT_IRQ);

    // Shared write side
    assign we_o    = we_i;
    assign word_o  = addr_i[2];   // Word within slot
    assign be_o    = be_i;
    assign wdata_o = wdata_i;

    always_comb begin
        case (slot)
            SLOT_GPIO: rsp_data = gpio_rdata_i;
            SLOT_RNG:  rsp_data = rng_rdata_i;
            SLOT_IRQ:  rsp_data = irq_rdata_i;
            default:   rsp_data = `ERR_DATA;
        endcase
    end

    // --------------------
    // Response register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
            rdata_o  <= '0;
        end else begin
            rvalid_o <= req_i;   // Writes answer too
            if (req_i) begin
                rdata_o <= rsp_data;
                err_o   <= (slot == SLOT_NONE);
            end
        end
    end

endmodule

//--- src/periph_pkg.sv
/*
 * Shared types for the peripheral block:
 * slot enum decoded from the address, data word type
 */
`include "periph_config.svh"

package periph_pkg;

    // Slot chosen by address bits 6:5
    typedef enum logic [1:0] {
        SLOT_GPIO = 2'd0,
        SLOT_RNG  = 2'd1,
        SLOT_IRQ  = 2'd2,
        SLOT_NONE = 2'd3   // Not populated, answers with error
    } periph_slot_e;

    typedef logic [`PERIPH_DATA_W-1:0] word_t;

endpackage

//--- src/periph_config.svh
/*
 * Global sizes and constants for the peripheral block:
 * bus widths, RNG FIFO sizing, LFSR seed, filler word
 * and interrupt source/target counts
 */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus
`define PERIPH_DATA_W   32
`define PERIPH_ADDR_W   8

// Random number FIFO
`define RNG_FIFO_DEPTH  16
`define RNG_CNT_W       9              // Level and pop counters
`define RNG_SEED        32'h1ACE_B00C  // Must be nonzero

// Answer for absent slots
`define ERR_DATA        32'hDEAD_BEEF

// Interrupt controller
`define NUM_IRQ_TARGETS 2
`define NUM_IRQ_SOURCES 2

`endif
